// ==== source/numericPkg.sv ====
package numericPkg;

    // Control bits per downsampled sample
    localparam int channelCount = 4;

    // One control vector, bit i belongs to channel i
    typedef logic [channelCount-1:0] sampleT;

    // Recursion state and lookup sums
    typedef logic signed [23:0] accT;

    // Decay factors in Q1.14
    localparam int coefFrac = 14;
    typedef logic signed [15:0] coefT;

    // Offset-binary output word
    typedef logic [13:0] resultT;

    // Forward recursion pole
    localparam coefT decayFwd = 16'sd14336;

    // Backward pole, also used by the lookahead
    localparam coefT decayBwd = 16'sd12288;

    // Per-channel weights folded into one sum
    // A set bit adds its weight and a clear bit subtracts it
    localparam accT channelGain [0:channelCount-1] = '{
        24'sd400,
        24'sd250,
        24'sd150,
        24'sd100
    };

endpackage

// ==== source/batchPkg.sv ====
package batchPkg;

    localparam int idxBits = 8;
    localparam int bankBits = 2;

    // Position within one batch, so batchDepth tops out at 256
    typedef logic [idxBits-1:0] batchIdxT;

    // One of the four rotating sample banks
    typedef logic [bankBits-1:0] bankT;

    // Bank in the upper bits, batch index below
    typedef logic [bankBits+idxBits-1:0] sampleAddrT;

endpackage

// ==== source/batchScheduler.sv ====
module batchScheduler #(
    parameter int batchDepth = 8
) (
    input  logic                 clkDS,
    input  logic                 rst,
    input  logic                 inValid,
    output batchPkg::sampleAddrT wrAddr,
    output batchPkg::sampleAddrT lookAddr,
    output batchPkg::sampleAddrT fwdAddr,
    output batchPkg::sampleAddrT bwdAddr,
    output logic                 lookClear,
    output logic                 bwdLoad,
    output logic                 computeOn,
    output batchPkg::batchIdxT   resWrFwdIdx,
    output batchPkg::batchIdxT   resWrBwdIdx,
    output batchPkg::batchIdxT   resRdIdx,
    output logic                 resBank,
    output logic                 resultReady
);
    import batchPkg::*;

    // Bank read and lookup sit between the address and the recursion
    localparam int recDelay = 2;
    // One more step until the recursion state is visible
    localparam int resDelay = 3;

    localparam int warmBits = $clog2(4 * batchDepth + 4);
    localparam logic [warmBits-1:0] computeStart = warmBits'(3 * batchDepth + recDelay);
    localparam logic [warmBits-1:0] readyStart = warmBits'(4 * batchDepth + recDelay);
    localparam batchIdxT lastIdx = batchIdxT'(batchDepth - 1);

    batchIdxT fwdIdx;
    batchIdxT revIdx;
    bankT period;
    bankT lookBank;
    bankT calcBank;
    logic [warmBits-1:0] warmCount;

    batchIdxT fwdIdxDly [resDelay];
    batchIdxT revIdxDly [resDelay];
    logic bankDly [resDelay];
    logic startDly [recDelay];

    assign revIdx = lastIdx - fwdIdx;

    // Lookahead trails the write bank by one, calculation by three
    assign lookBank = period - bankT'(1);
    assign calcBank = period - bankT'(3);

    assign wrAddr = {period, fwdIdx};
    assign lookAddr = {lookBank, revIdx};
    assign fwdAddr = {calcBank, fwdIdx};
    assign bwdAddr = {calcBank, revIdx};

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            fwdIdx <= '0;
            period <= '0;
            warmCount <= '0;
            computeOn <= 1'b0;
            resultReady <= 1'b0;
        end else if (inValid) begin
            if (fwdIdx == lastIdx) begin
                fwdIdx <= '0;
                period <= period + bankT'(1);
            end else begin
                fwdIdx <= fwdIdx + batchIdxT'(1);
            end
            if (!resultReady) begin
                warmCount <= warmCount + warmBits'(1);
            end
            // First forward element of batch 0 reaches the recursion here
            if (warmCount == computeStart) begin
                computeOn <= 1'b1;
            end
            if (warmCount == readyStart) begin
                resultReady <= 1'b1;
            end
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < resDelay; i++) begin
                fwdIdxDly[i] <= '0;
                revIdxDly[i] <= '0;
                bankDly[i] <= 1'b0;
            end
            for (int i = 0; i < recDelay; i++) begin
                startDly[i] <= 1'b0;
            end
        end else if (inValid) begin
            fwdIdxDly[0] <= fwdIdx;
            revIdxDly[0] <= revIdx;
            bankDly[0] <= period[0];
            startDly[0] <= (fwdIdx == '0);
            for (int i = 1; i < resDelay; i++) begin
                fwdIdxDly[i] <= fwdIdxDly[i-1];
                revIdxDly[i] <= revIdxDly[i-1];
                bankDly[i] <= bankDly[i-1];
            end
            for (int i = 1; i < recDelay; i++) begin
                startDly[i] <= startDly[i-1];
            end
        end
    end

    // Period boundary as seen by the recursions
    assign lookClear = startDly[recDelay-1];
    assign bwdLoad = startDly[recDelay-1];

    assign resWrFwdIdx = fwdIdxDly[resDelay-1];
    assign resWrBwdIdx = revIdxDly[resDelay-1];
    assign resRdIdx = fwdIdxDly[resDelay-1];
    assign resBank = bankDly[resDelay-1];

endmodule

// ==== source/sampleBanks.sv ====
module sampleBanks #(
    parameter int batchDepth = 8
) (
    input  logic                 clkDS,
    input  logic                 inValid,
    input  batchPkg::sampleAddrT wrAddr,
    input  numericPkg::sampleT   sample,
    input  batchPkg::sampleAddrT lookAddr,
    input  batchPkg::sampleAddrT fwdAddr,
    input  batchPkg::sampleAddrT bwdAddr,
    output numericPkg::sampleT   lookSample,
    output numericPkg::sampleT   fwdSample,
    output numericPkg::sampleT   bwdSample
);
    import numericPkg::*;
    import batchPkg::*;

    localparam int depth = 4 * batchDepth;

    sampleT mem [depth];

    // Banks are laid out back to back, batchDepth entries each
    function automatic int linear(sampleAddrT addr);
        bankT bank;
        batchIdxT idx;
        {bank, idx} = addr;
        return int'(bank) * batchDepth + int'(idx);
    endfunction

    always_ff @(posedge clkDS) begin
        if (inValid) begin
            mem[linear(wrAddr)] <= sample;
            // Read banks never match the write bank
            lookSample <= mem[linear(lookAddr)];
            fwdSample <= mem[linear(fwdAddr)];
            bwdSample <= mem[linear(bwdAddr)];
        end
    end

endmodule

// ==== source/coefLut.sv ====
module coefLut (
    input  logic               clkDS,
    input  logic               inValid,
    input  numericPkg::sampleT sample,
    output numericPkg::accT    sum
);
    import numericPkg::*;

    accT weighted;

    // Each control bit steers its channel weight up or down
    always_comb begin
        weighted = '0;
        for (int i = 0; i < channelCount; i++) begin
            if (sample[i]) begin
                weighted = weighted + channelGain[i];
            end else begin
                weighted = weighted - channelGain[i];
            end
        end
    end

    always_ff @(posedge clkDS) begin
        if (inValid) begin
            sum <= weighted;
        end
    end

endmodule

// ==== source/recursionUnit.sv ====
module recursionUnit (
    input  logic             clkDS,
    input  logic             rst,
    input  logic             inValid,
    input  numericPkg::accT  drive,
    input  numericPkg::coefT decay,
    input  logic             clear,
    input  logic             load,
    input  numericPkg::accT  loadVal,
    output numericPkg::accT  state
);
    import numericPkg::*;

    localparam int prodBits = $bits(accT) + $bits(coefT);

    accT base;
    logic signed [prodBits-1:0] product;

    // Previous state, or the value this step starts from
    always_comb begin
        if (load) begin
            base = loadVal;
        end else if (clear) begin
            base = '0;
        end else begin
            base = state;
        end
        product = base * decay;
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            state <= '0;
        end else if (inValid) begin
            state <= accT'(product >>> coefFrac) + drive;
        end
    end

endmodule

// ==== source/resultCombiner.sv ====
module resultCombiner #(
    parameter int batchDepth = 8
) (
    input  logic               clkDS,
    input  logic               rst,
    input  logic               inValid,
    input  numericPkg::accT    fwdState,
    input  numericPkg::accT    bwdState,
    input  batchPkg::batchIdxT resWrFwdIdx,
    input  batchPkg::batchIdxT resWrBwdIdx,
    input  batchPkg::batchIdxT resRdIdx,
    input  logic               resBank,
    input  logic               resultReady,
    output logic               outValid,
    output numericPkg::resultT out
);
    import numericPkg::*;
    import batchPkg::*;

    localparam int bufDepth = 2 * batchDepth;
    localparam int resBits = $bits(resultT);
    localparam int totalBits = $bits(accT) + 1;

    localparam logic signed [totalBits-1:0] satMax = totalBits'(2 ** (resBits - 1) - 1);
    localparam logic signed [totalBits-1:0] satMin = -totalBits'(2 ** (resBits - 1));

    accT fwdBuf [bufDepth];
    accT bwdBuf [bufDepth];
    int rdAddr;
    logic signed [totalBits-1:0] total;
    logic signed [resBits-1:0] clipped;

    function automatic int bufAddr(logic bank, batchIdxT idx);
        return bank ? batchDepth + int'(idx) : int'(idx);
    endfunction

    // Backward results land in reverse order, forward in sample order
    always_ff @(posedge clkDS) begin
        if (inValid) begin
            fwdBuf[bufAddr(resBank, resWrFwdIdx)] <= fwdState;
            bwdBuf[bufAddr(resBank, resWrBwdIdx)] <= bwdState;
        end
    end

    // Read the bank that finished filling last period
    assign rdAddr = bufAddr(!resBank, resRdIdx);

    always_comb begin
        total = fwdBuf[rdAddr] + bwdBuf[rdAddr];
        if (total > satMax) begin
            clipped = {1'b0, {(resBits-1){1'b1}}};
        end else if (total < satMin) begin
            clipped = {1'b1, {(resBits-1){1'b0}}};
        end else begin
            clipped = total[resBits-1:0];
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            outValid <= 1'b0;
            out <= '0;
        end else begin
            outValid <= inValid && resultReady;
            if (inValid && resultReady) begin
                // Offset binary, sign bit flipped
                out <= {~clipped[resBits-1], clipped[resBits-2:0]};
            end
        end
    end

endmodule

// ==== source/batchEstimator.sv ====
module batchEstimator #(
    parameter int batchDepth = 8
) (
    input  logic               clkDS,
    input  logic               rst,
    input  logic               inValid,
    input  numericPkg::sampleT sample,
    output logic               outValid,
    output numericPkg::resultT out
);
    import numericPkg::*;
    import batchPkg::*;

    sampleAddrT wrAddr;
    sampleAddrT lookAddr;
    sampleAddrT fwdAddr;
    sampleAddrT bwdAddr;
    logic lookClear;
    logic bwdLoad;
    logic computeOn;
    batchIdxT resWrFwdIdx;
    batchIdxT resWrBwdIdx;
    batchIdxT resRdIdx;
    logic resBank;
    logic resultReady;

    sampleT lookSample;
    sampleT fwdSample;
    sampleT bwdSample;

    accT lookDrive;
    accT fwdDrive;
    accT bwdDrive;
    accT lookState;
    accT fwdState;
    accT bwdState;

    batchScheduler #(
        .batchDepth(batchDepth)
    ) scheduler (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .wrAddr(wrAddr),
        .lookAddr(lookAddr),
        .fwdAddr(fwdAddr),
        .bwdAddr(bwdAddr),
        .lookClear(lookClear),
        .bwdLoad(bwdLoad),
        .computeOn(computeOn),
        .resWrFwdIdx(resWrFwdIdx),
        .resWrBwdIdx(resWrBwdIdx),
        .resRdIdx(resRdIdx),
        .resBank(resBank),
        .resultReady(resultReady)
    );

    sampleBanks #(
        .batchDepth(batchDepth)
    ) banks (
        .clkDS(clkDS),
        .inValid(inValid),
        .wrAddr(wrAddr),
        .sample(sample),
        .lookAddr(lookAddr),
        .fwdAddr(fwdAddr),
        .bwdAddr(bwdAddr),
        .lookSample(lookSample),
        .fwdSample(fwdSample),
        .bwdSample(bwdSample)
    );

    coefLut lookLut (.clkDS(clkDS), .inValid(inValid), .sample(lookSample), .sum(lookDrive));
    coefLut fwdLut (.clkDS(clkDS), .inValid(inValid), .sample(fwdSample), .sum(fwdDrive));
    coefLut bwdLut (.clkDS(clkDS), .inValid(inValid), .sample(bwdSample), .sum(bwdDrive));

    // Lookahead restarts from zero every period
    recursionUnit lookRec (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .drive(lookDrive),
        .decay(decayBwd),
        .clear(lookClear),
        .load(1'b0),
        .loadVal('0),
        .state(lookState)
    );

    // Held at zero history until batch 0 arrives
    recursionUnit fwdRec (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .drive(fwdDrive),
        .decay(decayFwd),
        .clear(!computeOn),
        .load(1'b0),
        .loadVal('0),
        .state(fwdState)
    );

    recursionUnit bwdRec (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .drive(bwdDrive),
        .decay(decayBwd),
        .clear(1'b0),
        .load(bwdLoad),
        .loadVal(lookState),
        .state(bwdState)
    );

    resultCombiner #(
        .batchDepth(batchDepth)
    ) combiner (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .fwdState(fwdState),
        .bwdState(bwdState),
        .resWrFwdIdx(resWrFwdIdx),
        .resWrBwdIdx(resWrBwdIdx),
        .resRdIdx(resRdIdx),
        .resBank(resBank),
        .resultReady(resultReady),
        .outValid(outValid),
        .out(out)
    );

endmodule

// ==== dv/batchEstimatorTb.sv ====
module batchEstimatorTb;
    timeunit 1ns;
    timeprecision 1ps;
    import numericPkg::*;

    localparam int batchDepth = 8;
    localparam int warmSteps = 4 * batchDepth + 3;
    localparam int totalSamples = 27 * batchDepth;
    // Constant, saturating and random stretches, then a random drain tail
    localparam int satStart = 6 * batchDepth;
    localparam int randStart = 12 * batchDepth;
    localparam int drainStart = 22 * batchDepth;
    localparam int refGain [4] = '{400, 250, 150, 100};

    logic clkDS = 1'b0;
    logic rst;
    logic inValid;
    sampleT sample;
    logic outValid;
    resultT out;

    sampleT stim [totalSamples];
    int gapBefore [totalSamples];
    resultT expVal [$];
    int expTest [$];
    bit expTop [$];
    string testName [6] = '{"warmupSilent", "stallHold", "constant0101", "saturate1111",
        "randomGaps", "pulseCount"};
    int testErr [6] = '{default: 0};
    int testTotal [6] = '{default: 0};
    int testDone [6] = '{default: 0};
    resultT expOut = '0;
    resultT outSeen = '0;
    bit expKnown = 1'b0;
    bit expTopCode = 1'b0;
    int curTest = 0;
    int stepsDone = 0;
    int resetEdges = 0;
    int pulseCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int failedTests = 0;
    int errTotal = 0;

    batchEstimator #(
        .batchDepth(batchDepth)
    ) i_batchEstimator (
        .clkDS(clkDS),
        .rst(rst),
        .inValid(inValid),
        .sample(sample),
        .outValid(outValid),
        .out(out)
    );

    always #20 clkDS = ~clkDS;

    // Signed sum of the channel weights, one sign per control bit
    function automatic accT lookupSum(sampleT s);
        accT acc;
        acc = '0;
        for (int i = 0; i < 4; i++) begin
            acc = s[i] ? acc + accT'(refGain[i]) : acc - accT'(refGain[i]);
        end
        return acc;
    endfunction

    // One recursion step, product truncated after the Q1.14 shift
    function automatic accT decayStep(accT state, int decay, accT drive);
        longint prod;
        prod = longint'(state) * longint'(decay);
        return accT'(prod >>> 14) + drive;
    endfunction

    function automatic void reportTest(int t);
        $display("test %-12s %s, %0d errors", testName[t], testErr[t] == 0 ? "ok" : "FAILED",
            testErr[t]);
    endfunction

    task automatic buildStimulus();
        for (int n = 0; n < totalSamples; n++) begin
            gapBefore[n] = 0;
            if (n < satStart) begin
                stim[n] = 4'b0101;
            end else if (n < randStart) begin
                stim[n] = 4'b1111;
            end else begin
                stim[n] = sampleT'($urandom);
                if ($urandom % 4 == 0) begin
                    gapBefore[n] = 1 + $urandom % 3;
                end
            end
            cycleLimit += 1 + gapBefore[n];
        end
        cycleLimit = 2 * (cycleLimit + 4) + 4 * batchDepth * 8;
    endtask

    task automatic buildExpected();
        accT fwd [totalSamples];
        accT bwd [totalSamples];
        accT prev;
        accT look;
        longint total;
        int test;
        prev = '0;
        for (int k = 0; k < totalSamples; k++) begin
            fwd[k] = decayStep(prev, 14336, lookupSum(stim[k]));
            prev = fwd[k];
        end
        // Lookahead over the next batch seeds the backward pass
        for (int b = 0; b < drainStart / batchDepth; b++) begin
            look = '0;
            for (int j = batchDepth - 1; j >= 0; j--) begin
                look = decayStep(look, 12288, lookupSum(stim[(b + 1) * batchDepth + j]));
            end
            for (int j = batchDepth - 1; j >= 0; j--) begin
                look = decayStep(look, 12288, lookupSum(stim[b * batchDepth + j]));
                bwd[b * batchDepth + j] = look;
            end
        end
        for (int n = 0; n < drainStart; n++) begin
            total = longint'(fwd[n]) + longint'(bwd[n]);
            if (total > 8191) begin
                total = 8191;
            end else if (total < -8192) begin
                total = -8192;
            end
            test = n < satStart ? 2 : (n < randStart ? 3 : 4);
            expVal.push_back(resultT'(total) ^ 14'h2000);
            expTest.push_back(test);
            expTop.push_back(n >= satStart + batchDepth && n < randStart - batchDepth);
            testTotal[test]++;
        end
    endtask

    always @(posedge clkDS) begin
        cycleCount <= cycleCount + 1;
        if (!rst) begin
            resetEdges <= resetEdges + 1;
        end else if (inValid) begin
            stepsDone <= stepsDone + 1;
        end
        if (cycleCount >= cycleLimit) begin
            $display("run stopped after %0d cycles with outputs still missing", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    // Outputs are stable mid-cycle, so the next expected value is lined up here
    always @(negedge clkDS) begin
        if (expKnown) begin
            testDone[curTest]++;
            if (testDone[curTest] == testTotal[curTest]) begin
                reportTest(curTest);
            end
        end
        outSeen = out;
        if (outValid) begin
            pulseCount++;
        end
        expKnown = outValid && expVal.size() != 0;
        if (expKnown) begin
            expOut = expVal.pop_front();
            curTest = expTest.pop_front();
            expTopCode = expTop.pop_front();
        end
    end

    warmupCheck: assert property (@(posedge clkDS)
        (resetEdges > 0 && stepsDone <= warmSteps) |-> !outValid)
    else begin
        $display("outValid went high after only %0d accepted steps", stepsDone);
        testErr[0]++;
    end

    stallCheck: assert property (@(posedge clkDS) disable iff (!rst)
        $past(!inValid) |-> (!outValid && out == $past(out)))
    else begin
        $display("outValid rose or out changed after a stalled step, time %0t", $time);
        testErr[1]++;
    end

    valueCheck: assert property (@(posedge clkDS) expKnown |-> out == expOut)
    else begin
        $display("mismatch %s: expected %h actual %h", testName[curTest], expOut, outSeen);
        testErr[curTest]++;
    end

    // Inner 1111 batches sit well above the positive limit
    topCheck: assert property (@(posedge clkDS) (expKnown && expTopCode) |-> out == '1)
    else begin
        $display("mismatch %s: expected %h actual %h", testName[curTest], 14'h3fff, outSeen);
        testErr[curTest]++;
    end

    initial begin
        void'($urandom(3));
        rst = 1'b0;
        inValid = 1'b0;
        sample = '0;
        buildStimulus();
        buildExpected();
        repeat (4) @(negedge clkDS);
        rst = 1'b1;
        for (int n = 0; n < totalSamples; n++) begin
            repeat (gapBefore[n]) begin
                inValid = 1'b0;
                sample = sampleT'($urandom);
                @(negedge clkDS);
            end
            inValid = 1'b1;
            sample = stim[n];
            @(negedge clkDS);
        end
        inValid = 1'b0;
        while (expVal.size() != 0 || expKnown) begin
            @(negedge clkDS);
        end
        repeat (3) @(negedge clkDS);
        pulseTotal: assert (pulseCount == stepsDone - warmSteps)
        else begin
            $display("saw %0d output pulses for %0d accepted steps", pulseCount, stepsDone);
            testErr[5]++;
        end
        reportTest(0);
        reportTest(1);
        reportTest(5);
        for (int t = 0; t < 6; t++) begin
            errTotal += testErr[t];
            if (testErr[t] != 0) begin
                failedTests++;
            end
        end
        $display("tests passed %0d, failed %0d, failing checks %0d", 6 - failedTests,
            failedTests, errTotal);
        if (failedTests == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/numericPkg.sv
source/batchPkg.sv
source/batchScheduler.sv
source/sampleBanks.sv
source/coefLut.sv
source/recursionUnit.sv
source/resultCombiner.sv
source/batchEstimator.sv
dv/batchEstimatorTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module batchEstimatorTb -f vlog.f

result=$(./obj_dir/VbatchEstimatorTb)
echo "$result"

if echo "$result" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
